//--- hw/peek_pkg.sv
`default_nettype none

package peek_pkg;

    localparam int REG_AW = 5;
    localparam int PEEK_AW = 10;

    // source ids as seen after key inversion; 4 to 7 are unused.
    typedef enum logic [2:0] {
        PEEK_REG       = 3'd0,
        PEEK_MEM_RAW   = 3'd1,
        PEEK_MEM_INSTR = 3'd2,
        PEEK_PC        = 3'd3
    } peek_src_e;

    typedef enum logic [1:0] {
        VIEW_RAW,
        VIEW_INSTR,
        VIEW_BLANK
    } view_mode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // one memory word, read either as plain data or as an instruction.
    typedef union packed {
        logic [31:0]   data;
        instr_fields_t instr;
    } mem_word_u;

endpackage

`default_nettype wire

//--- hw/board_pkg.sv
`default_nettype none

package board_pkg;

    localparam int NUM_DIGITS = 6;
    localparam int SEG_W = 7;

    // active low, bit 0 is segment a.
    function automatic logic [SEG_W-1:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03; // lower case b.
            4'hc: return 7'h46;
            4'hd: return 7'h21; // lower case d.
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/refresh_divider.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_divider #(
    parameter int DIV_CNT = 50
) (
    input  logic clk,
    input  logic rst_n,
    output logic refresh
);

    localparam int CNT_W = (DIV_CNT > 1) ? $clog2(DIV_CNT) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV_CNT - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt <= '0;
        end
        else if (cnt == LAST)
        begin
            cnt <= '0; // wrap.
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    // one-cycle enable at terminal count.
    assign refresh = (cnt == LAST);

endmodule

`default_nettype wire

//--- hw/peek_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module peek_ctrl #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           refresh,
    input  logic [peek_pkg::PEEK_AW-1:0]   sw,
    input  peek_pkg::peek_src_e            peek_id,
    input  logic [31:0]                    pc,
    input  logic [31:0]                    reg_rdata,
    input  peek_pkg::mem_word_u            mem_rdata,
    output logic                           rd_en,
    output logic [peek_pkg::REG_AW-1:0]    reg_raddr,
    output logic [$clog2(MEM_DEPTH)-1:0]   mem_raddr,
    output logic [31:0]                    peek_word,
    output peek_pkg::view_mode_e           view_mode,
    output logic                           word_valid
);

    import peek_pkg::*;

    localparam int MEM_AW = $clog2(MEM_DEPTH);

    logic [PEEK_AW-1:0] sw_q;
    logic [31:0]        pc_q;
    logic [31:0]        addr_ext;
    peek_src_e          src_q;
    logic               sel_valid;

    // sample step, payload only.
    always_ff @(posedge clk)
    begin
        if (refresh)
        begin
            sw_q <= sw;
            pc_q <= pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            src_q      <= PEEK_REG;
            rd_en      <= 1'b0;
            word_valid <= 1'b0;
        end
        else
        begin
            rd_en      <= refresh; // read step.
            word_valid <= rd_en;   // select step.
            if (refresh)
            begin
                src_q <= peek_id;
            end
        end
    end

    // memory index wraps modulo MEM_DEPTH.
    assign addr_ext  = {{(32 - PEEK_AW){1'b0}}, sw_q};
    assign reg_raddr = sw_q[REG_AW-1:0];
    assign mem_raddr = addr_ext[MEM_AW-1:0];

    assign sel_valid = (src_q <= PEEK_PC);

    always_comb
    begin
        peek_word = '0;
        view_mode = VIEW_BLANK;
        if (sel_valid)
        begin
            case (src_q)
                PEEK_REG:
                begin
                    peek_word = reg_rdata;
                    view_mode = VIEW_RAW;
                end
                PEEK_MEM_RAW:
                begin
                    peek_word = mem_rdata.data;
                    view_mode = VIEW_RAW;
                end
                PEEK_MEM_INSTR:
                begin
                    peek_word = mem_rdata.data;
                    view_mode = VIEW_INSTR;
                end
                default:
                begin
                    peek_word = pc_q;
                    view_mode = VIEW_RAW;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/state_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module state_regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [peek_pkg::REG_AW-1:0] waddr,
    input  logic [31:0]                 wdata,
    input  logic                        rd_en,
    input  logic [peek_pkg::REG_AW-1:0] raddr,
    output logic [31:0]                 rdata
);

    import peek_pkg::*;

    localparam int NUM_REGS = 1 << REG_AW;

    logic [31:0] regs [NUM_REGS];

    // mirror of the core register file.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata; // x0 stays zero.
        end
    end

    // same-edge write is not visible here.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else if (rd_en)
        begin
            rdata <= regs[raddr];
        end
    end

endmodule

`default_nettype wire

//--- hw/state_mem.sv
`timescale 1ns/1ps
`default_nettype none

module state_mem #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         we,
    input  logic [$clog2(MEM_DEPTH)-1:0] waddr,
    input  peek_pkg::mem_word_u          wdata,
    input  logic                         rd_en,
    input  logic [$clog2(MEM_DEPTH)-1:0] raddr,
    output peek_pkg::mem_word_u          rdata
);

    import peek_pkg::*;

    mem_word_u mem [MEM_DEPTH];

    // block ram style write port.
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // read-first against a write on the same edge.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else if (rd_en)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- hw/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  word_valid,
    input  peek_pkg::mem_word_u   peek_word,
    input  peek_pkg::view_mode_e  view_mode,
    output logic [board_pkg::NUM_DIGITS-1:0][board_pkg::SEG_W-1:0] digits
);

    import peek_pkg::*;
    import board_pkg::*;

    logic [NUM_DIGITS-1:0][SEG_W-1:0] digits_d;

    always_comb
    begin
        logic [4*NUM_DIGITS-1:0] nibbles;
        nibbles  = '0;
        digits_d = '1;
        case (view_mode)
            VIEW_RAW:
            begin
                nibbles = peek_word.data[4*NUM_DIGITS-1:0];
            end
            VIEW_INSTR:
            begin
                // two hex digits per field.
                nibbles = {3'b000, peek_word.instr.rs2,
                           3'b000, peek_word.instr.rs1,
                           3'b000, peek_word.instr.rd};
            end
            default:
            begin
                nibbles = '0;
            end
        endcase
        if (view_mode != VIEW_BLANK)
        begin
            for (int i = 0; i < NUM_DIGITS; i++)
            begin
                digits_d[i] = hex_to_seg(nibbles[4*i +: 4]);
            end
        end
    end

    // held between refreshes.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            digits <= '1; // all segments off.
        end
        else if (word_valid)
        begin
            digits <= digits_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/board_peek_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_peek_top #(
    parameter int DIV_CNT   = 50,
    parameter int MEM_DEPTH = 1024
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           reg_we,
    input  logic [peek_pkg::REG_AW-1:0]    reg_waddr,
    input  logic [31:0]                    reg_wdata,
    input  logic                           mem_we,
    input  logic [$clog2(MEM_DEPTH)-1:0]   mem_waddr,
    input  logic [31:0]                    mem_wdata,
    input  logic [31:0]                    pc,
    input  logic [peek_pkg::PEEK_AW-1:0]   sw,
    input  logic [2:0]                     key_n,
    output logic [board_pkg::SEG_W-1:0]    hex0_n,
    output logic [board_pkg::SEG_W-1:0]    hex1_n,
    output logic [board_pkg::SEG_W-1:0]    hex2_n,
    output logic [board_pkg::SEG_W-1:0]    hex3_n,
    output logic [board_pkg::SEG_W-1:0]    hex4_n,
    output logic [board_pkg::SEG_W-1:0]    hex5_n
);

    import peek_pkg::*;
    import board_pkg::*;

    localparam int MEM_AW = $clog2(MEM_DEPTH);

    logic                             refresh;
    logic                             rd_en;
    logic                             word_valid;
    logic [REG_AW-1:0]                reg_raddr;
    logic [MEM_AW-1:0]                mem_raddr;
    logic [31:0]                      reg_rdata;
    mem_word_u                        mem_rdata;
    logic [31:0]                      peek_word;
    view_mode_e                       view_mode;
    peek_src_e                        peek_id;
    logic [NUM_DIGITS-1:0][SEG_W-1:0] digits;

    assign peek_id = peek_src_e'(~key_n); // keys pressed low.

    refresh_divider #(
        .DIV_CNT (DIV_CNT)
    ) u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .refresh (refresh)
    );

    peek_ctrl #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .refresh    (refresh),
        .sw         (sw),
        .peek_id    (peek_id),
        .pc         (pc),
        .reg_rdata  (reg_rdata),
        .mem_rdata  (mem_rdata),
        .rd_en      (rd_en),
        .reg_raddr  (reg_raddr),
        .mem_raddr  (mem_raddr),
        .peek_word  (peek_word),
        .view_mode  (view_mode),
        .word_valid (word_valid)
    );

    state_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (reg_we),
        .waddr (reg_waddr),
        .wdata (reg_wdata),
        .rd_en (rd_en),
        .raddr (reg_raddr),
        .rdata (reg_rdata)
    );

    state_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .rd_en (rd_en),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

    seg_display u_disp (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .peek_word  (peek_word),
        .view_mode  (view_mode),
        .digits     (digits)
    );

    assign hex0_n = digits[0];
    assign hex1_n = digits[1];
    assign hex2_n = digits[2];
    assign hex3_n = digits[3];
    assign hex4_n = digits[4];
    assign hex5_n = digits[5];

endmodule

`default_nettype wire

//--- sim/board_peek_chk.sv
`timescale 1ns/1ps
`default_nettype none

module board_peek_chk (
    input logic clk,
    input logic rst_n,
    input logic refresh,
    input logic rd_en,
    input logic word_valid
);

    int unsigned err_cnt = 0;

    a_rd_after_refresh: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en == $past(refresh))
    else
    begin
        $error("rd_en does not follow refresh by one cycle");
        err_cnt++;
    end

    a_valid_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
        word_valid == $past(rd_en))
    else
    begin
        $error("word_valid does not follow rd_en by one cycle");
        err_cnt++;
    end

    // single-cycle strobes only.
    a_rd_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |=> !rd_en)
    else
    begin
        $error("rd_en high in two consecutive cycles");
        err_cnt++;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        word_valid |=> !word_valid)
    else
    begin
        $error("word_valid high in two consecutive cycles");
        err_cnt++;
    end

endmodule

bind peek_ctrl board_peek_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .refresh    (refresh),
    .rd_en      (rd_en),
    .word_valid (word_valid)
);

`default_nettype wire

//--- sim/tb_board_peek.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_peek;

    localparam int DIV_CNT    = 8;
    localparam int MEM_DEPTH  = 64;
    localparam int MEM_AW     = $clog2(MEM_DEPTH);
    localparam int HOLD       = 2 * DIV_CNT + 4;
    localparam int NUM_CHECKS = 61;
    localparam int TIMEOUT_NS = NUM_CHECKS * (2 * DIV_CNT + 8) * 4 + 1000;

    // active-low glyphs, bit 0 is segment a.
    localparam logic [6:0] SEG_LUT [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    typedef logic [5:0][6:0] digit_row_t;

    logic              clk;
    logic              rst_n;
    logic              reg_we;
    logic [4:0]        reg_waddr;
    logic [31:0]       reg_wdata;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_waddr;
    logic [31:0]       mem_wdata;
    logic [31:0]       pc;
    logic [9:0]        sw;
    logic [2:0]        key_n;
    wire  [6:0]        hex0_n;
    wire  [6:0]        hex1_n;
    wire  [6:0]        hex2_n;
    wire  [6:0]        hex3_n;
    wire  [6:0]        hex4_n;
    wire  [6:0]        hex5_n;
    digit_row_t        hex_n;
    digit_row_t        exp_hex;
    logic              check_now;
    int                checks_done;
    integer            seed;
    logic [31:0]       reg_model [32];
    logic [31:0]       mem_model [MEM_DEPTH];
    logic [MEM_AW-1:0] mem_addrs [8];

    board_peek_top #(
        .DIV_CNT   (DIV_CNT),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .pc        (pc),
        .sw        (sw),
        .key_n     (key_n),
        .hex0_n    (hex0_n),
        .hex1_n    (hex1_n),
        .hex2_n    (hex2_n),
        .hex3_n    (hex3_n),
        .hex4_n    (hex4_n),
        .hex5_n    (hex5_n)
    );

    assign hex_n = {hex5_n, hex4_n, hex3_n, hex2_n, hex1_n, hex0_n};

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_and_stop();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    for (genvar g = 0; g < 6; g++)
    begin : g_hex_chk
        a_hex_match: assert property (@(posedge clk) check_now |-> (hex_n[g] == exp_hex[g]))
        else
        begin
            $display("ERROR: hex%0d_n expected %h actual %h", g, $sampled(exp_hex[g]),
                     $sampled(hex_n[g]));
            fail_and_stop();
        end
    end

    function automatic logic [31:0] model_word(input logic [9:0] addr, input logic [2:0] src);
        case (src)
            3'd0: return reg_model[addr[4:0]];
            3'd1, 3'd2: return mem_model[addr % MEM_DEPTH]; // index wraps.
            3'd3: return pc;
            default: return 32'd0;
        endcase
    endfunction

    function automatic digit_row_t expected_view(input logic [31:0] word, input logic [2:0] src);
        logic [23:0] nib;
        digit_row_t  row;
        row = '1;
        if (src == 3'd2)
        begin
            // rs2, rs1, rd as byte-wide fields.
            nib = {3'b000, word[24:20], 3'b000, word[19:15], 3'b000, word[11:7]};
        end
        else
        begin
            nib = word[23:0];
        end
        if (src < 3'd4)
        begin
            for (int i = 0; i < 6; i++)
            begin
                row[i] = SEG_LUT[nib[4*i +: 4]];
            end
        end
        return row;
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        reg_we    = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        if (addr != 5'd0)
        begin
            reg_model[addr] = data; // x0 stays zero.
        end
        @(posedge clk);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic write_mem(input logic [MEM_AW-1:0] addr, input logic [31:0] data);
        mem_we          = 1'b1;
        mem_waddr       = addr;
        mem_wdata       = data;
        mem_model[addr] = data;
        @(posedge clk);
        #1;
        mem_we = 1'b0;
    endtask

    task automatic check_display(input digit_row_t exp);
        exp_hex   = exp;
        check_now = 1'b1;
        @(posedge clk);
        #1;
        check_now = 1'b0;
        checks_done++;
    endtask

    task automatic peek_check(input logic [9:0] addr, input logic [2:0] src);
        sw    = addr;
        key_n = ~src; // keys pressed low.
        repeat (HOLD) @(posedge clk);
        #1;
        check_display(expected_view(model_word(addr, src), src));
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog: run timed out after %0d ns", TIMEOUT_NS);
        fail_and_stop();
    end

    initial
    begin
        wait (u_dut.u_ctrl.u_chk.err_cnt != 0);
        $display("protocol assertion on peek_ctrl strobes failed");
        fail_and_stop();
    end

    initial
    begin
        logic [31:0] val;
        seed        = 32'hd3d3_e516;
        rst_n       = 1'b0;
        reg_we      = 1'b0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        mem_we      = 1'b0;
        mem_waddr   = '0;
        mem_wdata   = '0;
        pc          = '0;
        sw          = '0;
        key_n       = 3'b111;
        check_now   = 1'b0;
        exp_hex     = '1;
        checks_done = 0;
        for (int i = 0; i < 32; i++)
        begin
            reg_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_display({6{7'h7f}}); // blank until the first refresh.

        for (int r = 1; r < 32; r++)
        begin
            write_reg(5'(r), $random(seed));
        end
        write_reg(5'd0, $random(seed));
        for (int r = 0; r < 32; r++)
        begin
            val = $random(seed);
            peek_check({val[4:0], 5'(r)}, 3'd0);
        end

        for (int i = 0; i < 8; i++)
        begin
            val          = $random(seed);
            mem_addrs[i] = val[MEM_AW-1:0];
            write_mem(mem_addrs[i], $random(seed));
        end
        for (int i = 0; i < 8; i++)
        begin
            peek_check(10'(mem_addrs[i]), 3'd1);
        end
        for (int i = 0; i < 2; i++)
        begin
            val = $random(seed);
            peek_check(10'(mem_addrs[i]) + 10'(MEM_DEPTH * (1 + val[2:0])), 3'd1);
        end
        for (int i = 0; i < 8; i++)
        begin
            peek_check(10'(mem_addrs[i]), 3'd2);
        end

        for (int i = 0; i < 2; i++)
        begin
            pc = $random(seed);
            peek_check(10'd0, 3'd3);
        end
        for (int id = 4; id < 8; id++)
        begin
            val = $random(seed);
            peek_check(val[9:0], 3'(id));
        end

        // switches stay put across the rewrite.
        peek_check(10'd7, 3'd0);
        write_reg(5'd7, $random(seed));
        peek_check(10'd7, 3'd0);
        peek_check(10'(mem_addrs[3]), 3'd1);
        write_mem(mem_addrs[3], $random(seed));
        peek_check(10'(mem_addrs[3]), 3'd1);

        if (checks_done == NUM_CHECKS)
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d checks ran", checks_done, NUM_CHECKS);
            fail_and_stop();
        end
    end

endmodule

`default_nettype wire

//--- src.f
hw/peek_pkg.sv
hw/board_pkg.sv
hw/refresh_divider.sv
hw/peek_ctrl.sv
hw/state_regfile.sv
hw/state_mem.sv
hw/seg_display.sv
hw/board_peek_top.sv
sim/board_peek_chk.sv
sim/tb_board_peek.sv
